/* hdl/dma_pkg.sv */
// DMA controller shared definitions
// bus widths, control-bus register map, start key,
// control-word bit positions and the sequencer state type
package dma_pkg;

	// bus and buffer sizes
	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;
	localparam int BLK_AW = 10;
	// 32 device lines
	localparam int DEV_W  = 5;

	// control-bus register map
	localparam logic [1:0] REG_CTRL = 2'd0;
	localparam logic [1:0] REG_LEN  = 2'd1;
	localparam logic [1:0] REG_SRC  = 2'd2;
	localparam logic [1:0] REG_DST  = 2'd3;

	// must sit in control bits 27..16 to start a transfer
	localparam logic [11:0] START_KEY = 12'hfed;

	// control word layout
	localparam int CTRL_BUSY    = 31;
	localparam int CTRL_ERR     = 30;
	localparam int CTRL_INCS_N  = 29;
	localparam int CTRL_INCD_N  = 28;
	localparam int CTRL_ON_TRIG = 15;
	localparam int CTRL_DEV_LSB = 10;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT,
		ST_READ,
		ST_READ_GAP,
		ST_PRE_WRITE,
		ST_WRITE,
		ST_WRITE_GAP
	} dma_state_e;

	// one bit wider than the buffer index so a full 1024-word block fits
	typedef logic [BLK_AW:0] blk_cnt_t;

endpackage

/* hdl/dma_block_buffer.sv */
`timescale 1ns/1ns
// DMA block buffer
// 1024-word memory filled in order by reads and drained in order
// by writes, head word registered out of the memory
module dma_block_buffer
	import dma_pkg::*;
(
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_clear,
	input  logic                i_push,
	input  logic                i_pop,
	input  logic [DATA_W-1:0]   i_push_data,
	output logic [DATA_W-1:0]   o_head
);

	logic [DATA_W-1:0]   mem [0:(1<<BLK_AW)-1];
	blk_cnt_t            wr_ptr;
	blk_cnt_t            rd_ptr;
	blk_cnt_t            rd_next;

	// read port addressed by the next pointer so head follows one cycle later
	assign rd_next = i_clear ? '0 : (i_pop ? rd_ptr + 1'b1 : rd_ptr);

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_clear)
			wr_ptr <= '0;
		else if (i_push)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			rd_ptr <= '0;
		else
			rd_ptr <= rd_next;
	end

	// plain synchronous ram, one write port and one registered read port
	always_ff @(posedge i_clk)
	begin
		if (i_push)
			mem[wr_ptr[BLK_AW-1:0]] <= i_push_data;
		o_head <= mem[rd_next[BLK_AW-1:0]];
	end

endmodule

/* hdl/dma_ctrl_regs.sv */
`timescale 1ns/1ns
// DMA control-bus slave
// length, source and destination registers, transfer options,
// sticky error bit, start command decode and device trigger select
module dma_ctrl_regs
	import dma_pkg::*;
(
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_swb_cyc,
	input  logic                    i_swb_stb,
	input  logic                    i_swb_we,
	input  logic [1:0]              i_swb_addr,
	input  logic [DATA_W-1:0]       i_swb_data,
	output logic                    o_swb_ack,
	output logic [DATA_W-1:0]       o_swb_data,
	input  logic [(1<<DEV_W)-1:0]   i_dev_ints,
	input  logic                    i_busy,
	input  logic                    i_rd_done,
	input  logic                    i_wr_done,
	input  logic                    i_bus_err,
	output logic                    o_start,
	output logic                    o_trig_ok,
	output logic [ADDR_W-1:0]       o_len,
	output logic [ADDR_W-1:0]       o_raddr,
	output logic [ADDR_W-1:0]       o_waddr,
	output blk_cnt_t                o_blk_len
);

	logic                idle;
	logic                swb_wr;
	logic                start_cmd;
	logic [ADDR_W-1:0]   r_len;
	logic [ADDR_W-1:0]   r_raddr;
	logic [ADDR_W-1:0]   r_waddr;
	logic                r_err;
	logic                r_incs_n;
	logic                r_incd_n;
	logic                r_on_trig;
	logic [DEV_W-1:0]    r_dev_sel;
	logic [BLK_AW-1:0]   r_blk_field;
	logic [DATA_W-1:0]   ctrl_word;

	////////////////////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////////////////////

	// start pulse in flight still counts as busy, sequencer sees it next cycle
	assign idle   = !i_busy && !o_start;
	assign swb_wr = i_swb_cyc && i_swb_stb && i_swb_we && idle;

	// key in 27..16, busy/err bits clear, something to move
	assign start_cmd = swb_wr && (i_swb_addr == REG_CTRL)
		&& (i_swb_data[CTRL_INCD_N-1:CTRL_ON_TRIG+1] == START_KEY)
		&& (i_swb_data[CTRL_BUSY:CTRL_ERR] == 2'b00)
		&& (r_len != '0);

	// every strobe gets its ack one cycle later, busy or not
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_swb_ack <= 1'b0;
		else
			o_swb_ack <= i_swb_cyc && i_swb_stb;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_start <= 1'b0;
		else
			o_start <= start_cmd;
	end

	// options from the control word
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_incs_n    <= 1'b0;
			r_incd_n    <= 1'b0;
			r_on_trig   <= 1'b0;
			r_dev_sel   <= '0;
			r_blk_field <= '0;
		end
		else if (swb_wr && (i_swb_addr == REG_CTRL))
		begin
			r_incs_n    <= i_swb_data[CTRL_INCS_N];
			r_incd_n    <= i_swb_data[CTRL_INCD_N];
			r_on_trig   <= i_swb_data[CTRL_ON_TRIG];
			r_dev_sel   <= i_swb_data[CTRL_DEV_LSB +: DEV_W];
			r_blk_field <= i_swb_data[BLK_AW-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// length and address counters
	////////////////////////////////////////////////////////////////////////////

	// software writes only land while idle, done pulses only come while busy
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_len   <= '0;
			r_raddr <= '0;
			r_waddr <= '0;
		end
		else
		begin
			if (swb_wr && (i_swb_addr == REG_LEN))
				r_len <= i_swb_data[ADDR_W-1:0];
			else if (i_wr_done)
				r_len <= r_len - 1'b1;
			// byte address in, word address kept
			if (swb_wr && (i_swb_addr == REG_SRC))
				r_raddr <= i_swb_data[ADDR_W+1:2];
			else if (i_rd_done && !r_incs_n)
				r_raddr <= r_raddr + 1'b1;
			if (swb_wr && (i_swb_addr == REG_DST))
				r_waddr <= i_swb_data[ADDR_W+1:2];
			else if (i_wr_done && !r_incd_n)
				r_waddr <= r_waddr + 1'b1;
		end
	end

	// sticky error, cleared by any idle control write
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_err <= 1'b0;
		else if (swb_wr && (i_swb_addr == REG_CTRL))
			r_err <= 1'b0;
		else if (i_bus_err)
			r_err <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// readback
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		ctrl_word                          = '0;
		ctrl_word[CTRL_BUSY]               = i_busy;
		ctrl_word[CTRL_ERR]                = r_err;
		ctrl_word[CTRL_INCS_N]             = r_incs_n;
		ctrl_word[CTRL_INCD_N]             = r_incd_n;
		ctrl_word[CTRL_ON_TRIG]            = r_on_trig;
		ctrl_word[CTRL_DEV_LSB +: DEV_W]   = r_dev_sel;
		ctrl_word[BLK_AW-1:0]              = r_blk_field;
	end

	always_ff @(posedge i_clk)
	begin
		case (i_swb_addr)
		REG_CTRL: o_swb_data <= ctrl_word;
		REG_LEN:  o_swb_data <= {{(DATA_W-ADDR_W){1'b0}}, r_len};
		REG_SRC:  o_swb_data <= {r_raddr, 2'b00};
		REG_DST:  o_swb_data <= {r_waddr, 2'b00};
		default:  o_swb_data <= '0;
		endcase
	end

	// field of zero stands for a full 1024-word block
	assign o_blk_len = {(r_blk_field == '0), r_blk_field};
	assign o_trig_ok = !r_on_trig || i_dev_ints[r_dev_sel];
	assign o_len     = r_len;
	assign o_raddr   = r_raddr;
	assign o_waddr   = r_waddr;

endmodule

/* hdl/dma_sequencer.sv */
`timescale 1ns/1ns
// DMA transfer sequencer
// walks each block through a read phase into the buffer and a write
// phase out of it, one master request at a time, and raises the
// interrupt at the end of the transfer or on a bus error
module dma_sequencer
	import dma_pkg::*;
(
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_start,
	input  logic                i_trig_ok,
	input  logic [ADDR_W-1:0]   i_len,
	input  logic [ADDR_W-1:0]   i_raddr,
	input  logic [ADDR_W-1:0]   i_waddr,
	input  blk_cnt_t            i_blk_len,
	output logic                o_busy,
	output logic                o_rd_done,
	output logic                o_wr_done,
	output logic                o_bus_err,
	output logic                o_mwb_cyc,
	output logic                o_mwb_stb,
	output logic                o_mwb_we,
	output logic [ADDR_W-1:0]   o_mwb_addr,
	input  logic                i_mwb_ack,
	input  logic                i_mwb_err,
	output logic                o_buf_clear,
	output logic                o_buf_push,
	output logic                o_buf_pop,
	output logic                o_interrupt
);

	dma_state_e   state;
	blk_cnt_t     blk_size;
	blk_cnt_t     rd_cnt;
	blk_cnt_t     wr_cnt;
	logic         rd_ack;
	logic         wr_ack;
	logic         bus_err;
	logic         last_rd;
	logic         last_wr;
	logic         final_wr;

	////////////////////////////////////////////////////////////////////////////
	// bus events
	////////////////////////////////////////////////////////////////////////////

	// err wins over ack if a slave ever raises both
	assign bus_err = o_mwb_stb && i_mwb_err;
	assign rd_ack  = (state == ST_READ) && i_mwb_ack && !i_mwb_err;
	assign wr_ack  = (state == ST_WRITE) && i_mwb_ack && !i_mwb_err;

	// counts hold the acks seen so far, +1 covers the one arriving now
	assign last_rd = (rd_cnt + 1'b1 == blk_size);
	assign last_wr = (wr_cnt + 1'b1 == blk_size);

	// length still includes this word, it drops at the same edge
	assign final_wr = wr_ack && last_wr && (i_len == ADDR_W'(1));

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
			ST_IDLE:
				if (i_start)
					state <= ST_WAIT;
			// at least one cycle here, so the first strobe trails the start ack
			ST_WAIT:
				if (i_trig_ok)
					state <= ST_READ;
			ST_READ:
				if (i_mwb_err)
					state <= ST_IDLE;
				else if (i_mwb_ack)
					state <= last_rd ? ST_PRE_WRITE : ST_READ_GAP;
			ST_READ_GAP:
				state <= ST_READ;
			// cyc low for a cycle, buffer head settles on word 0
			ST_PRE_WRITE:
				state <= ST_WRITE;
			ST_WRITE:
				if (i_mwb_err)
					state <= ST_IDLE;
				else if (i_mwb_ack)
				begin
					if (!last_wr)
						state <= ST_WRITE_GAP;
					else if (i_len == ADDR_W'(1))
						state <= ST_IDLE;
					else
						state <= ST_WAIT;
				end
			ST_WRITE_GAP:
				state <= ST_WRITE;
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// block size and per-block counters, rebuilt while waiting
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			blk_size <= '0;
			rd_cnt   <= '0;
			wr_cnt   <= '0;
		end
		else if (state == ST_WAIT)
		begin
			rd_cnt <= '0;
			wr_cnt <= '0;
			// short tail block when less than a block is left
			if (i_len < {{(ADDR_W-BLK_AW-1){1'b0}}, i_blk_len})
				blk_size <= i_len[BLK_AW:0];
			else
				blk_size <= i_blk_len;
		end
		else
		begin
			if (rd_ack)
				rd_cnt <= rd_cnt + 1'b1;
			if (wr_ack)
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// one cycle after the last write ack or the error ack, busy already low
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_interrupt <= 1'b0;
		else
			o_interrupt <= bus_err || final_wr;
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	assign o_busy    = (state != ST_IDLE);
	assign o_mwb_cyc = (state == ST_READ) || (state == ST_READ_GAP)
		|| (state == ST_WRITE) || (state == ST_WRITE_GAP);
	assign o_mwb_stb = (state == ST_READ) || (state == ST_WRITE);
	assign o_mwb_we  = (state == ST_PRE_WRITE) || (state == ST_WRITE)
		|| (state == ST_WRITE_GAP);

	// register side moves the addresses on the ack edge, after the strobe
	assign o_mwb_addr = o_mwb_we ? i_waddr : i_raddr;

	assign o_rd_done   = rd_ack;
	assign o_wr_done   = wr_ack;
	assign o_bus_err   = bus_err;
	assign o_buf_clear = (state == ST_WAIT) && i_trig_ok;
	assign o_buf_push  = rd_ack;
	assign o_buf_pop   = wr_ack;

endmodule

/* hdl/dma_top.sv */
`timescale 1ns/1ns
// DMA controller top level
// control-bus register slave, transfer sequencer and block buffer
// joined to the control bus, the master bus and the device lines
module dma_top
	import dma_pkg::*;
(
	input  logic                    i_clk,
	input  logic                    i_reset,
	// control bus
	input  logic                    i_swb_cyc,
	input  logic                    i_swb_stb,
	input  logic                    i_swb_we,
	input  logic [1:0]              i_swb_addr,
	input  logic [DATA_W-1:0]       i_swb_data,
	output logic                    o_swb_ack,
	output logic [DATA_W-1:0]       o_swb_data,
	// master bus
	output logic                    o_mwb_cyc,
	output logic                    o_mwb_stb,
	output logic                    o_mwb_we,
	output logic [ADDR_W-1:0]       o_mwb_addr,
	output logic [DATA_W-1:0]       o_mwb_data,
	input  logic                    i_mwb_ack,
	input  logic [DATA_W-1:0]       i_mwb_data,
	input  logic                    i_mwb_err,
	// device lines and completion
	input  logic [(1<<DEV_W)-1:0]   i_dev_ints,
	output logic                    o_interrupt
);

	logic                start;
	logic                trig_ok;
	logic [ADDR_W-1:0]   len;
	logic [ADDR_W-1:0]   raddr;
	logic [ADDR_W-1:0]   waddr;
	blk_cnt_t            blk_len;
	logic                busy;
	logic                rd_done;
	logic                wr_done;
	logic                bus_err;
	logic                buf_clear;
	logic                buf_push;
	logic                buf_pop;

	dma_ctrl_regs u_regs (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_swb_cyc  (i_swb_cyc),
		.i_swb_stb  (i_swb_stb),
		.i_swb_we   (i_swb_we),
		.i_swb_addr (i_swb_addr),
		.i_swb_data (i_swb_data),
		.o_swb_ack  (o_swb_ack),
		.o_swb_data (o_swb_data),
		.i_dev_ints (i_dev_ints),
		.i_busy     (busy),
		.i_rd_done  (rd_done),
		.i_wr_done  (wr_done),
		.i_bus_err  (bus_err),
		.o_start    (start),
		.o_trig_ok  (trig_ok),
		.o_len      (len),
		.o_raddr    (raddr),
		.o_waddr    (waddr),
		.o_blk_len  (blk_len)
	);

	dma_sequencer u_seq (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_start     (start),
		.i_trig_ok   (trig_ok),
		.i_len       (len),
		.i_raddr     (raddr),
		.i_waddr     (waddr),
		.i_blk_len   (blk_len),
		.o_busy      (busy),
		.o_rd_done   (rd_done),
		.o_wr_done   (wr_done),
		.o_bus_err   (bus_err),
		.o_mwb_cyc   (o_mwb_cyc),
		.o_mwb_stb   (o_mwb_stb),
		.o_mwb_we    (o_mwb_we),
		.o_mwb_addr  (o_mwb_addr),
		.i_mwb_ack   (i_mwb_ack),
		.i_mwb_err   (i_mwb_err),
		.o_buf_clear (buf_clear),
		.o_buf_push  (buf_push),
		.o_buf_pop   (buf_pop),
		.o_interrupt (o_interrupt)
	);

	// write data comes straight off the buffer head
	dma_block_buffer u_buf (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_clear     (buf_clear),
		.i_push      (buf_push),
		.i_pop       (buf_pop),
		.i_push_data (i_mwb_data),
		.o_head      (o_mwb_data)
	);

endmodule

/* tests/dma_top_assert.sv */
`timescale 1ns/1ns
// bus protocol assertions for the DMA controller
// master strobe framing and hold, control-bus ack timing,
// single-cycle interrupt
module dma_top_assert
	import dma_pkg::*;
(
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_swb_cyc,
	input  logic                i_swb_stb,
	input  logic                o_swb_ack,
	input  logic                o_mwb_cyc,
	input  logic                o_mwb_stb,
	input  logic                o_mwb_we,
	input  logic [ADDR_W-1:0]   o_mwb_addr,
	input  logic                i_mwb_ack,
	input  logic                i_mwb_err,
	input  logic                o_interrupt
);

	// number of assertion failures so far
	int unsigned fail_count = 0;

	// strobe only inside a cycle, which opens with a strobe
	// and keeps one direction until cyc drops
	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_mwb_stb || o_mwb_cyc
		|-> o_mwb_cyc && ($past(o_mwb_cyc) ? $stable(o_mwb_we) : o_mwb_stb))
	else
	begin
		$error("master strobe outside a bus cycle or bus cycle framing broken");
		fail_count++;
	end

	// request held until the slave answers
	a_stb_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_mwb_stb && !i_mwb_ack && !i_mwb_err
		|=> o_mwb_stb && $stable(o_mwb_addr) && $stable(o_mwb_we))
	else
	begin
		$error("master request changed before ack or err");
		fail_count++;
	end

	a_swb_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		i_swb_cyc && i_swb_stb |=> o_swb_ack)
	else
	begin
		$error("control strobe not acknowledged one cycle later");
		fail_count++;
	end

	a_irq_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
		o_interrupt |=> !o_interrupt)
	else
	begin
		$error("interrupt high for two cycles in a row");
		fail_count++;
	end

endmodule

/* tests/dma_top_tb.sv */
`timescale 1ns/1ns
// testbench for the DMA controller
// runs a table of transfers through the control bus, models a 256-word
// memory on the master bus with random ack delay and error injection,
// and checks memory contents, registers and interrupt pulses
module dma_top_tb
	import dma_pkg::*;
();

	localparam int MEM_WORDS = 256;
	localparam int N_ROWS    = 6;

	// one transfer with its expected error bit
	typedef struct {
		logic [ADDR_W-1:0]   src;
		logic [ADDR_W-1:0]   dst;
		logic [ADDR_W-1:0]   len;
		logic [BLK_AW-1:0]   field;
		logic                incs_n;
		logic                incd_n;
		logic                on_trig;
		logic [DEV_W-1:0]    dev;
		logic                err_en;
		logic [ADDR_W-1:0]   err_addr;
		logic                exp_err;
	} xfer_row_t;

	logic                    i_clk;
	logic                    i_reset;
	logic                    i_swb_cyc;
	logic                    i_swb_stb;
	logic                    i_swb_we;
	logic [1:0]              i_swb_addr;
	logic [DATA_W-1:0]       i_swb_data;
	logic                    o_swb_ack;
	logic [DATA_W-1:0]       o_swb_data;
	logic                    o_mwb_cyc;
	logic                    o_mwb_stb;
	logic                    o_mwb_we;
	logic [ADDR_W-1:0]       o_mwb_addr;
	logic [DATA_W-1:0]       o_mwb_data;
	logic                    i_mwb_ack;
	logic [DATA_W-1:0]       i_mwb_data;
	logic                    i_mwb_err;
	logic [(1<<DEV_W)-1:0]   i_dev_ints;
	logic                    o_interrupt;

	xfer_row_t           rows [N_ROWS];
	logic [DATA_W-1:0]   mem [MEM_WORDS];
	logic [DATA_W-1:0]   snap [MEM_WORDS];
	logic [DATA_W-1:0]   exp_mem [MEM_WORDS];
	logic                err_en;
	logic [ADDR_W-1:0]   err_addr;
	int                  ack_wait;
	int                  irq_count;
	int                  cycle_count;
	int                  timeout_limit;

	dma_top dma_top_i (.*);

	bind dma_top dma_top_assert u_assert (.*);

	always #20 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////////////////////
	// failure reporting and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	// one control-bus access with the ack expected two edges after the strobe is driven
	task automatic swb_access(input logic we, input logic [1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		@(posedge i_clk);
		i_swb_cyc  <= 1'b1;
		i_swb_stb  <= 1'b1;
		i_swb_we   <= we;
		i_swb_addr <= addr;
		i_swb_data <= wdata;
		@(posedge i_clk);
		i_swb_cyc <= 1'b0;
		i_swb_stb <= 1'b0;
		i_swb_we  <= 1'b0;
		@(posedge i_clk);
		if (!o_swb_ack)
			abort_run("control bus access was not acknowledged");
		rdata = o_swb_data;
	endtask

	function automatic logic [DATA_W-1:0] make_ctrl(input xfer_row_t row, input logic go);
		logic [DATA_W-1:0] w;
		w                              = '0;
		w[CTRL_INCS_N]                 = row.incs_n;
		w[CTRL_INCD_N]                 = row.incd_n;
		w[CTRL_ON_TRIG]                = row.on_trig;
		w[CTRL_DEV_LSB +: DEV_W]       = row.dev;
		w[BLK_AW-1:0]                  = row.field;
		if (go)
			w[27:16] = START_KEY;
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// master bus memory model
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		if (i_reset || i_mwb_ack || i_mwb_err)
		begin
			i_mwb_ack <= 1'b0;
			i_mwb_err <= 1'b0;
			ack_wait = $urandom_range(3, 0);
		end
		else if (o_mwb_stb)
		begin
			if (ack_wait != 0)
				ack_wait--;
			else if (err_en && !o_mwb_we && (o_mwb_addr == err_addr))
				i_mwb_err <= 1'b1;
			else
			begin
				if (o_mwb_we)
					mem[o_mwb_addr[7:0]] = o_mwb_data;
				else
					i_mwb_data <= mem[o_mwb_addr[7:0]];
				i_mwb_ack <= 1'b1;
			end
		end
	end

	// count interrupt pulses and check that busy and cyc are already low with each
	always @(posedge i_clk)
	begin
		if (!i_reset && o_interrupt)
		begin
			irq_count <= irq_count + 1;
			check_bit("busy", dma_top_i.busy, 1'b0);
			check_bit("o_mwb_cyc", o_mwb_cyc, 1'b0);
		end
	end

	// watchdog and assertion watch
	always @(posedge i_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_limit)
			abort_run($sformatf("timeout, run did not finish in %0d cycles", timeout_limit));
		if (dma_top_i.u_assert.fail_count != 0)
			abort_run("a bus protocol assertion failed");
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequences
	////////////////////////////////////////////////////////////////////////////

	// byte addresses come back word aligned and options without the key do not start
	task automatic check_registers();
		logic [DATA_W-1:0] rd;
		swb_access(1'b1, REG_LEN, 32'h0000_0123, rd);
		swb_access(1'b1, REG_SRC, 32'h0000_0107, rd);
		swb_access(1'b1, REG_DST, 32'hffff_fffe, rd);
		swb_access(1'b1, REG_CTRL, 32'h2000_d6a5, rd);
		swb_access(1'b0, REG_LEN, '0, rd);
		check_word("length", rd, 32'h0000_0123);
		swb_access(1'b0, REG_SRC, '0, rd);
		check_word("source", rd, 32'h0000_0104);
		swb_access(1'b0, REG_DST, '0, rd);
		check_word("destination", rd, 32'hffff_fffc);
		swb_access(1'b0, REG_CTRL, '0, rd);
		check_word("control", rd, 32'h2000_d6a5);
	endtask

	task automatic run_row(input xfer_row_t row);
		logic [DATA_W-1:0]   rd;
		logic [7:0]          s;
		logic [7:0]          d;
		int                  blk;
		int                  n_words;
		int                  irq_before;
		// expected image from the snapshot over the words of whole blocks only
		snap    = mem;
		exp_mem = mem;
		blk     = (row.field == 0) ? 1024 : int'(row.field);
		n_words = int'(row.len);
		if (row.err_en)
			n_words = (int'(row.err_addr - row.src) / blk) * blk;
		for (int i = 0; i < n_words; i++)
		begin
			s          = row.src[7:0] + (row.incs_n ? 8'd0 : 8'(i));
			d          = row.dst[7:0] + (row.incd_n ? 8'd0 : 8'(i));
			exp_mem[d] = snap[s];
		end
		err_en   = row.err_en;
		err_addr = row.err_addr;
		swb_access(1'b1, REG_LEN, DATA_W'(row.len), rd);
		swb_access(1'b1, REG_SRC, {row.src, 2'b00}, rd);
		swb_access(1'b1, REG_DST, {row.dst, 2'b00}, rd);
		irq_before = irq_count;
		swb_access(1'b1, REG_CTRL, make_ctrl(row, 1'b1), rd);
		if (row.on_trig)
		begin
			// length writes bounce off while stalled on the device line
			swb_access(1'b1, REG_LEN, 32'h0000_03ff, rd);
			swb_access(1'b0, REG_LEN, '0, rd);
			check_word("length while busy", rd, DATA_W'(row.len));
			swb_access(1'b0, REG_CTRL, '0, rd);
			check_bit("busy", rd[CTRL_BUSY], 1'b1);
			repeat (50)
			begin
				@(posedge i_clk);
				check_bit("o_mwb_stb", o_mwb_stb, 1'b0);
			end
			i_dev_ints[row.dev] <= 1'b1;
		end
		while (irq_count == irq_before)
			@(posedge i_clk);
		repeat (4) @(posedge i_clk);
		check_word("interrupt pulses", DATA_W'(irq_count), DATA_W'(irq_before + 1));
		i_dev_ints <= '0;
		swb_access(1'b0, REG_CTRL, '0, rd);
		check_bit("busy", rd[CTRL_BUSY], 1'b0);
		check_bit("error", rd[CTRL_ERR], row.exp_err);
		swb_access(1'b0, REG_LEN, '0, rd);
		check_word("length", rd, DATA_W'(row.len - n_words));
		for (int a = 0; a < MEM_WORDS; a++)
			check_word($sformatf("mem[%02h]", a), mem[a], exp_mem[a]);
		if (row.exp_err)
		begin
			swb_access(1'b1, REG_CTRL, make_ctrl(row, 1'b0), rd);
			swb_access(1'b0, REG_CTRL, '0, rd);
			check_bit("error after clear", rd[CTRL_ERR], 1'b0);
		end
	endtask

	initial
	begin
		i_clk      = 1'b0;
		i_reset    = 1'b1;
		i_swb_cyc  = 1'b0;
		i_swb_stb  = 1'b0;
		i_swb_we   = 1'b0;
		i_swb_addr = '0;
		i_swb_data = '0;
		i_mwb_ack  = 1'b0;
		i_mwb_data = '0;
		i_mwb_err  = 1'b0;
		i_dev_ints = '0;
		err_en     = 1'b0;
		err_addr   = '0;
		irq_count  = 0;
		cycle_count = 0;
		void'($urandom(32'hd5642450));
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = $urandom;
		// src, dst, len, block field, incs_n, incd_n, wait, line, err on, err addr, err
		rows[0] = '{30'h00, 30'h80, 30'd37, 10'd8, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 30'h0, 1'b0};
		rows[1] = '{30'h30, 30'ha0, 30'd12, 10'd5, 1'b1, 1'b0, 1'b0, 5'd0, 1'b0, 30'h0, 1'b0};
		rows[2] = '{30'h38, 30'hf0, 30'd9, 10'd4, 1'b0, 1'b1, 1'b0, 5'd0, 1'b0, 30'h0, 1'b0};
		rows[3] = '{30'h10, 30'hc0, 30'd20, 10'd0, 1'b0, 1'b0, 1'b1, 5'd13, 1'b0, 30'h0, 1'b0};
		rows[4] = '{30'h40, 30'hd0, 30'd20, 10'd8, 1'b0, 1'b0, 1'b0, 5'd0, 1'b1, 30'h4b, 1'b1};
		rows[5] = '{30'h60, 30'h20, 30'd3, 10'd1, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 30'h0, 1'b0};
		timeout_limit = 2000;
		for (int r = 0; r < N_ROWS; r++)
			timeout_limit += int'(rows[r].len) * 16;
		repeat (5) @(posedge i_clk);
		i_reset <= 1'b0;
		check_registers();
		for (int r = 0; r < N_ROWS; r++)
			run_row(rows[r]);
		if (dma_top_i.u_assert.fail_count != 0)
			abort_run("a bus protocol assertion failed");
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

/* build.f */
hdl/dma_pkg.sv
hdl/dma_block_buffer.sv
hdl/dma_ctrl_regs.sv
hdl/dma_sequencer.sv
hdl/dma_top.sv
tests/dma_top_assert.sv
tests/dma_top_tb.sv

/* Bender.yml */
package:
  name: dma_top

sources:
  # RTL in compile order
  - hdl/dma_pkg.sv
  - hdl/dma_block_buffer.sv
  - hdl/dma_ctrl_regs.sv
  - hdl/dma_sequencer.sv
  - hdl/dma_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - tests/dma_top_assert.sv
      - tests/dma_top_tb.sv
